// File: rtl/vreg_pkg.sv
package vreg_pkg;

  //====================
  // Widths
  //====================
  // Instruction ID from the ROB
  localparam int IID_W    = 7;
  localparam int AREG_W   = 5;
  localparam int PREG_W   = 6;
  localparam int AREG_NUM = 32;
  localparam int PREG_NUM = 64;

  //====================
  // State encodings
  //====================
  // One-hot lifecycle of the physical register
  typedef enum logic [4:0] {
    DEALLOC  = 5'b00001,
    WF_ALLOC = 5'b00010,
    ALLOC    = 5'b00100,
    RETIRE   = 5'b01000,
    RELEASE  = 5'b10000
  } lc_state_e;

  // WB means the producer result has been written
  typedef enum logic {
    IDLE = 1'b0,
    WB   = 1'b1
  } wb_state_e;

  //====================
  // Payloads
  //====================
  // Creating instruction info, one per dispatch slot
  typedef struct packed {
    logic [IID_W-1:0]  iid;
    logic [AREG_W-1:0] dstv_reg;
    logic [PREG_W-1:0] rel_vreg;
  } vreg_info_t;

  // One retire slot of the ROB
  typedef struct packed {
    logic             iid_updt_vld;
    logic [IID_W-1:0] iid_updt_val;
    logic             wb_retire_vld;
  } retire_slot_t;

  typedef logic [AREG_NUM-1:0] areg_mask_t;
  typedef logic [PREG_NUM-1:0] preg_mask_t;

endpackage

// File: rtl/vreg_info_reg.sv
module vreg_info_reg #(
  parameter int NUM_DISP = 5
) (
  input  logic                                 sm_clk,
  input  logic                                 cpurst_b,
  input  logic [NUM_DISP-1:0]                  create_vld,
  input  vreg_pkg::vreg_info_t [NUM_DISP-1:0]  disp,
  output vreg_pkg::vreg_info_t                 info,
  output logic                                 create_any
);

  vreg_pkg::vreg_info_t sel_info;

  //====================
  // Dispatch slot select
  //====================
  // AND-OR mux, create_vld is one-hot
  always_comb begin
    sel_info = '0;
    for (int i = 0; i < NUM_DISP; i++) begin
      if (create_vld[i]) begin
        sel_info = sel_info | disp[i];
      end
    end
  end

  // Shared create strobe for both FSMs
  assign create_any = |create_vld;

  //====================
  // Information register
  //====================
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      info <= '0;
    end
    else if (create_any) begin
      info <= sel_info;
    end
  end

endmodule

// File: rtl/vreg_retire_match.sv
module vreg_retire_match #(
  parameter int NUM_RETIRE = 4
) (
  input  logic                                     sm_clk,
  input  logic                                     cpurst_b,
  input  logic                                     state_alloc,
  input  logic [vreg_pkg::IID_W-1:0]               iid,
  input  vreg_pkg::retire_slot_t [NUM_RETIRE-1:0]  retire,
  output logic                                     retire_hit
);

  logic [NUM_RETIRE-1:0] iid_match;
  logic [NUM_RETIRE-1:0] iid_match_updt;
  logic [NUM_RETIRE-1:0] slot_hit;

  //====================
  // IID match registers
  //====================
  // Compare one cycle ahead of retirement to keep
  // the retire path short
  for (genvar i = 0; i < NUM_RETIRE; i++) begin : g_slot
    assign iid_match_updt[i] = state_alloc
                               && (iid == retire[i].iid_updt_val);

    always_ff @(posedge sm_clk or negedge cpurst_b) begin
      if (!cpurst_b) begin
        iid_match[i] <= 1'b0;
      end
      else if (retire[i].iid_updt_vld) begin
        iid_match[i] <= iid_match_updt[i];
      end
    end

    assign slot_hit[i] = retire[i].wb_retire_vld && iid_match[i];
  end

  //====================
  // Retire indication
  //====================
  // A match left over from an earlier ALLOC period
  // must not retire the entry again
  assign retire_hit = state_alloc && (|slot_hit);

endmodule

// File: rtl/vreg_lifecycle_fsm.sv
module vreg_lifecycle_fsm (
  input  logic                 sm_clk,
  input  logic                 cpurst_b,
  input  logic                 dealloc_vld,
  input  logic                 create_any,
  input  logic                 release_vld,
  input  logic                 flush,
  input  logic                 retire_hit,
  input  logic                 wb_done,
  input  logic                 dealloc_mask,
  output vreg_pkg::lc_state_e  state,
  output logic                 cur_state_dealloc,
  output logic                 cur_state_alloc_release
);

  vreg_pkg::lc_state_e next_state;
  logic                wb_masked;

  // Write-back only counts while dealloc is not masked
  assign wb_masked = wb_done && !dealloc_mask;

  //====================
  // State register
  //====================
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      state <= vreg_pkg::DEALLOC;
    end
    else begin
      state <= next_state;
    end
  end

  //====================
  // Next state
  //====================
  always_comb begin
    case (state)
      vreg_pkg::DEALLOC: begin
        if (dealloc_vld && !flush)
          next_state = vreg_pkg::WF_ALLOC;
        else
          next_state = vreg_pkg::DEALLOC;
      end
      vreg_pkg::WF_ALLOC: begin
        if (flush)
          next_state = vreg_pkg::DEALLOC;
        else if (create_any)
          next_state = vreg_pkg::ALLOC;
        else
          next_state = vreg_pkg::WF_ALLOC;
      end
      vreg_pkg::ALLOC: begin
        // Flush wins over release and retire
        if (flush)
          next_state = vreg_pkg::DEALLOC;
        else if (release_vld && wb_masked)
          next_state = vreg_pkg::DEALLOC;
        else if (release_vld)
          next_state = vreg_pkg::RELEASE;
        else if (retire_hit)
          next_state = vreg_pkg::RETIRE;
        else
          next_state = vreg_pkg::ALLOC;
      end
      vreg_pkg::RETIRE: begin
        if (release_vld && wb_masked)
          next_state = vreg_pkg::DEALLOC;
        else if (release_vld)
          next_state = vreg_pkg::RELEASE;
        else
          next_state = vreg_pkg::RETIRE;
      end
      vreg_pkg::RELEASE: begin
        // Wait here for the producer's write-back
        if (wb_masked)
          next_state = vreg_pkg::DEALLOC;
        else
          next_state = vreg_pkg::RELEASE;
      end
      default: next_state = vreg_pkg::DEALLOC;
    endcase
  end

  // State flags for the allocator
  assign cur_state_dealloc       = (state == vreg_pkg::DEALLOC);
  assign cur_state_alloc_release = (state == vreg_pkg::ALLOC)
                                   || (state == vreg_pkg::RELEASE);

endmodule

// File: rtl/vreg_wb_fsm.sv
module vreg_wb_fsm (
  input  logic sm_clk,
  input  logic cpurst_b,
  input  logic wb_vld,
  input  logic create_any,
  input  logic state_dealloc,
  output logic wb_done
);

  vreg_pkg::wb_state_e wb_state;
  vreg_pkg::wb_state_e wb_next;

  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      wb_state <= vreg_pkg::IDLE;
    end
    else if (create_any) begin
      // New producer, result not yet written
      wb_state <= vreg_pkg::IDLE;
    end
    else begin
      wb_state <= wb_next;
    end
  end

  always_comb begin
    case (wb_state)
      vreg_pkg::IDLE: wb_next = wb_vld ? vreg_pkg::WB : vreg_pkg::IDLE;
      // Held until the lifecycle frees the register
      vreg_pkg::WB:   wb_next = state_dealloc ? vreg_pkg::IDLE : vreg_pkg::WB;
      default:        wb_next = vreg_pkg::IDLE;
    endcase
  end

  assign wb_done = (wb_state == vreg_pkg::WB);

endmodule

// File: rtl/vreg_release_decode.sv
module vreg_release_decode (
  input  vreg_pkg::vreg_info_t  info,
  input  vreg_pkg::lc_state_e   state,
  input  logic                  retire_hit,
  input  logic                  wb_done,
  output vreg_pkg::preg_mask_t  rel_vreg_expand,
  output vreg_pkg::areg_mask_t  dreg,
  output logic                  retired_released_wb
);

  vreg_pkg::preg_mask_t rel_expand;
  vreg_pkg::areg_mask_t dstv_expand;
  logic                 state_retire;
  logic                 state_release;

  assign state_retire  = (state == vreg_pkg::RETIRE);
  assign state_release = (state == vreg_pkg::RELEASE);

  //====================
  // Release vector
  //====================
  // retire_hit already carries the ALLOC qualifier
  assign rel_expand      = vreg_pkg::preg_mask_t'(1) << info.rel_vreg;
  assign rel_vreg_expand = {vreg_pkg::PREG_NUM{retire_hit}} & rel_expand;

  //====================
  // Recovery vector
  //====================
  assign dstv_expand = vreg_pkg::areg_mask_t'(1) << info.dstv_reg;
  assign dreg        = {vreg_pkg::AREG_NUM{state_retire}} & dstv_expand;

  // Includes the retiring cycle itself for the flush logic
  assign retired_released_wb = (retire_hit || state_retire || state_release)
                               ? wb_done : 1'b1;

endmodule

// File: rtl/vreg_entry.sv
module vreg_entry #(
  parameter int NUM_DISP   = 5,
  parameter int NUM_RETIRE = 4
) (
  input  logic                                     sm_clk,
  input  logic                                     cpurst_b,
  input  vreg_pkg::vreg_info_t [NUM_DISP-1:0]      disp,
  input  logic [NUM_DISP-1:0]                      create_vld,
  input  vreg_pkg::retire_slot_t [NUM_RETIRE-1:0]  retire,
  input  logic                                     dealloc_vld,
  input  logic                                     release_vld,
  input  logic                                     wb_vld,
  input  logic                                     flush,
  input  logic                                     dealloc_mask,
  output logic                                     cur_state_dealloc,
  output logic                                     cur_state_alloc_release,
  output vreg_pkg::areg_mask_t                     dreg,
  output vreg_pkg::preg_mask_t                     rel_vreg_expand,
  output logic                                     retired_released_wb
);

  vreg_pkg::vreg_info_t info;
  vreg_pkg::lc_state_e  state;
  logic                 create_any;
  logic                 wb_done;
  logic                 retire_hit;
  logic                 state_alloc;

  // Decoded lifecycle flag for the match registers
  assign state_alloc = (state == vreg_pkg::ALLOC);

  //====================
  // Creation info
  //====================
  vreg_info_reg #(
    .NUM_DISP   (NUM_DISP)
  ) u_info_reg (
    .sm_clk     (sm_clk),
    .cpurst_b   (cpurst_b),
    .create_vld (create_vld),
    .disp       (disp),
    .info       (info),
    .create_any (create_any)
  );

  //====================
  // Retire matching
  //====================
  vreg_retire_match #(
    .NUM_RETIRE  (NUM_RETIRE)
  ) u_retire_match (
    .sm_clk      (sm_clk),
    .cpurst_b    (cpurst_b),
    .state_alloc (state_alloc),
    .iid         (info.iid),
    .retire      (retire),
    .retire_hit  (retire_hit)
  );

  //====================
  // State machines
  //====================
  vreg_lifecycle_fsm u_lifecycle_fsm (
    .sm_clk                  (sm_clk),
    .cpurst_b                (cpurst_b),
    .dealloc_vld             (dealloc_vld),
    .create_any              (create_any),
    .release_vld             (release_vld),
    .flush                   (flush),
    .retire_hit              (retire_hit),
    .wb_done                 (wb_done),
    .dealloc_mask            (dealloc_mask),
    .state                   (state),
    .cur_state_dealloc       (cur_state_dealloc),
    .cur_state_alloc_release (cur_state_alloc_release)
  );

  vreg_wb_fsm u_wb_fsm (
    .sm_clk        (sm_clk),
    .cpurst_b      (cpurst_b),
    .wb_vld        (wb_vld),
    .create_any    (create_any),
    .state_dealloc (cur_state_dealloc),
    .wb_done       (wb_done)
  );

  // Release, recovery and write-back status outputs
  vreg_release_decode u_release_decode (
    .info                (info),
    .state               (state),
    .retire_hit          (retire_hit),
    .wb_done             (wb_done),
    .rel_vreg_expand     (rel_vreg_expand),
    .dreg                (dreg),
    .retired_released_wb (retired_released_wb)
  );

endmodule

// File: sim/vreg_entry_sva.sv
module vreg_entry_sva (
  input logic                 sm_clk,
  input logic                 cpurst_b,
  input logic                 cur_state_dealloc,
  input logic                 cur_state_alloc_release,
  input vreg_pkg::areg_mask_t dreg,
  input vreg_pkg::preg_mask_t rel_vreg_expand
);
  timeunit 1ns;
  timeprecision 1ps;

  // At most one physical register released per entry
  a_rel_onehot: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    $onehot0(rel_vreg_expand))
    else $error("rel_vreg_expand has more than one bit set");

  a_dreg_onehot: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    $onehot0(dreg))
    else $error("dreg has more than one bit set");

  // Free and allocated flags exclude each other
  a_flags_excl: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    !(cur_state_dealloc && cur_state_alloc_release))
    else $error("cur_state_dealloc and cur_state_alloc_release both high");

endmodule

bind vreg_entry vreg_entry_sva u_sva (
  .sm_clk                  (sm_clk),
  .cpurst_b                (cpurst_b),
  .cur_state_dealloc       (cur_state_dealloc),
  .cur_state_alloc_release (cur_state_alloc_release),
  .dreg                    (dreg),
  .rel_vreg_expand         (rel_vreg_expand)
);

// File: sim/vreg_entry_tb.sv
module vreg_entry_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_DISP     = 5;
  localparam int NUM_RETIRE   = 4;
  localparam int RESET_CYCLES = 2;

  // Pulse bits {dealloc_vld, release_vld, wb_vld, flush, dealloc_mask}
  localparam logic [4:0] P_NONE    = 5'b00000;
  localparam logic [4:0] P_DEALLOC = 5'b10000;
  localparam logic [4:0] P_RELEASE = 5'b01000;
  localparam logic [4:0] P_WB      = 5'b00100;
  localparam logic [4:0] P_FLUSH   = 5'b00010;
  localparam logic [4:0] P_MASK    = 5'b00001;

  typedef struct {
    int                         create_slot;
    int                         info_idx;
    int                         updt_slot;
    logic [vreg_pkg::IID_W-1:0] updt_iid;
    int                         wbret_slot;
    logic [4:0]                 pulses;
    logic [2:0]                 flags;      // {dealloc, alloc_release, retired_released_wb}
    int                         dreg_idx;   // -1 means all zero
    int                         rel_idx;
  } row_t;

  logic                                     sm_clk;
  logic                                     cpurst_b;
  vreg_pkg::vreg_info_t [NUM_DISP-1:0]      disp;
  logic [NUM_DISP-1:0]                      create_vld;
  vreg_pkg::retire_slot_t [NUM_RETIRE-1:0]  retire;
  logic                                     dealloc_vld;
  logic                                     release_vld;
  logic                                     wb_vld;
  logic                                     flush;
  logic                                     dealloc_mask;
  logic                                     cur_state_dealloc;
  logic                                     cur_state_alloc_release;
  vreg_pkg::areg_mask_t                     dreg;
  vreg_pkg::preg_mask_t                     rel_vreg_expand;
  logic                                     retired_released_wb;

  row_t                 rows[$];
  vreg_pkg::vreg_info_t infos[5];
  logic [31:0]          lfsr_state;
  int                   cycle_count;
  int                   cycle_limit;

  vreg_entry #(
    .NUM_DISP   (NUM_DISP),
    .NUM_RETIRE (NUM_RETIRE)
  ) dut0 (
    .sm_clk                  (sm_clk),
    .cpurst_b                (cpurst_b),
    .disp                    (disp),
    .create_vld              (create_vld),
    .retire                  (retire),
    .dealloc_vld             (dealloc_vld),
    .release_vld             (release_vld),
    .wb_vld                  (wb_vld),
    .flush                   (flush),
    .dealloc_mask            (dealloc_mask),
    .cur_state_dealloc       (cur_state_dealloc),
    .cur_state_alloc_release (cur_state_alloc_release),
    .dreg                    (dreg),
    .rel_vreg_expand         (rel_vreg_expand),
    .retired_released_wb     (retired_released_wb)
  );

  initial begin
    sm_clk = 1'b0;
    forever #50 sm_clk = ~sm_clk;
  end

  //====================
  // Helpers
  //====================
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic vreg_pkg::vreg_info_t rand_info();
    logic [$bits(vreg_pkg::vreg_info_t)-1:0] v;
    v = '0;
    for (int b = 0; b < $bits(vreg_pkg::vreg_info_t); b++) begin
      v = {v[$bits(vreg_pkg::vreg_info_t)-2:0], lfsr_bit()};
    end
    return vreg_pkg::vreg_info_t'(v);
  endfunction

  function automatic logic [vreg_pkg::IID_W-1:0] rand_iid();
    logic [vreg_pkg::IID_W-1:0] v;
    v = '0;
    for (int b = 0; b < vreg_pkg::IID_W; b++) begin
      v = {v[vreg_pkg::IID_W-2:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic vreg_pkg::areg_mask_t dreg_mask(int idx);
    vreg_pkg::areg_mask_t m;
    m = '0;
    if (idx >= 0) m[idx] = 1'b1;
    return m;
  endfunction

  function automatic vreg_pkg::preg_mask_t rel_mask(int idx);
    vreg_pkg::preg_mask_t m;
    m = '0;
    if (idx >= 0) m[idx] = 1'b1;
    return m;
  endfunction

  task automatic stop_run();
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_flag(string what, logic got, logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s expected %b got %b", $time, what, exp, got);
      stop_run();
    end
  endtask

  task automatic check_dreg(string what, vreg_pkg::areg_mask_t got, vreg_pkg::areg_mask_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s expected %h got %h", $time, what, exp, got);
      stop_run();
    end
  endtask

  task automatic check_rel(string what, vreg_pkg::preg_mask_t got, vreg_pkg::preg_mask_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s expected %h got %h", $time, what, exp, got);
      stop_run();
    end
  endtask

  task automatic add_row(int cs, int ci, int us, logic [vreg_pkg::IID_W-1:0] uiid, int ws,
                         logic [4:0] p, logic [2:0] f, int di, int ri);
    row_t r;
    r.create_slot = cs;
    r.info_idx    = ci;
    r.updt_slot   = us;
    r.updt_iid    = uiid;
    r.wbret_slot  = ws;
    r.pulses      = p;
    r.flags       = f;
    r.dreg_idx    = di;
    r.rel_idx     = ri;
    rows.push_back(r);
  endtask

  // Slots not addressed by the row carry random junk
  task automatic apply_row(row_t r);
    create_vld = '0;
    for (int s = 0; s < NUM_DISP; s++) begin
      disp[s] = rand_info();
    end
    if (r.create_slot >= 0) begin
      disp[r.create_slot]       = infos[r.info_idx];
      create_vld[r.create_slot] = 1'b1;
    end
    for (int s = 0; s < NUM_RETIRE; s++) begin
      retire[s].iid_updt_vld  = 1'b0;
      retire[s].iid_updt_val  = rand_iid();
      retire[s].wb_retire_vld = 1'b0;
    end
    if (r.updt_slot >= 0) begin
      retire[r.updt_slot].iid_updt_vld = 1'b1;
      retire[r.updt_slot].iid_updt_val = r.updt_iid;
    end
    if (r.wbret_slot >= 0) retire[r.wbret_slot].wb_retire_vld = 1'b1;
    {dealloc_vld, release_vld, wb_vld, flush, dealloc_mask} = r.pulses;
  endtask

  task automatic check_row(int i, row_t r);
    check_flag($sformatf("row %0d cur_state_dealloc", i), cur_state_dealloc, r.flags[2]);
    check_flag($sformatf("row %0d cur_state_alloc_release", i), cur_state_alloc_release,
               r.flags[1]);
    check_flag($sformatf("row %0d retired_released_wb", i), retired_released_wb, r.flags[0]);
    check_dreg($sformatf("row %0d dreg", i), dreg, dreg_mask(r.dreg_idx));
    check_rel($sformatf("row %0d rel_vreg_expand", i), rel_vreg_expand, rel_mask(r.rel_idx));
  endtask

  //====================
  // Stimulus table
  //====================
  task automatic build_table();
    infos[0] = '{iid: 7'h2A, dstv_reg: 5'd9,  rel_vreg: 6'd45};
    infos[1] = '{iid: 7'h15, dstv_reg: 5'd3,  rel_vreg: 6'd7};
    infos[2] = '{iid: 7'h33, dstv_reg: 5'd30, rel_vreg: 6'd62};
    infos[3] = '{iid: 7'h08, dstv_reg: 5'd17, rel_vreg: 6'd0};
    infos[4] = '{iid: 7'h5C, dstv_reg: 5'd12, rel_vreg: 6'd20};
    // Reset values, then allocate from slot 3 and retire on slot 2
    add_row(-1, 0, -1, 7'h00, -1, P_NONE,    3'b101, -1, -1);
    add_row(-1, 0, -1, 7'h00, -1, P_DEALLOC, 3'b101, -1, -1);
    add_row( 3, 0, -1, 7'h00, -1, P_NONE,    3'b001, -1, -1);
    add_row(-1, 0,  2, 7'h2A, -1, P_NONE,    3'b011, -1, -1);
    add_row(-1, 0, -1, 7'h00,  2, P_NONE,    3'b010, -1, 45);
    // Second retire on the stale slot 2 match is ignored in RETIRE
    add_row(-1, 0, -1, 7'h00,  2, P_NONE,    3'b000,  9, -1);
    // Release before write-back waits in RELEASE
    add_row(-1, 0, -1, 7'h00, -1, P_RELEASE, 3'b000,  9, -1);
    add_row(-1, 0, -1, 7'h00, -1, P_NONE,    3'b010, -1, -1);
    add_row(-1, 0, -1, 7'h00, -1, P_WB,      3'b010, -1, -1);
    add_row(-1, 0, -1, 7'h00, -1, P_NONE,    3'b011, -1, -1);
    add_row(-1, 0, -1, 7'h00, -1, P_NONE,    3'b101, -1, -1);
    // Non-matching IID clears the stale slot 2 match
    add_row(-1, 0, -1, 7'h00, -1, P_DEALLOC, 3'b101, -1, -1);
    add_row( 1, 1, -1, 7'h00, -1, P_NONE,    3'b001, -1, -1);
    add_row(-1, 0,  2, 7'h16, -1, P_NONE,    3'b011, -1, -1);
    add_row(-1, 0, -1, 7'h00,  2, P_NONE,    3'b011, -1, -1);
    // Release after write-back goes straight to DEALLOC
    add_row(-1, 0, -1, 7'h00, -1, P_WB,      3'b011, -1, -1);
    add_row(-1, 0, -1, 7'h00, -1, P_RELEASE, 3'b011, -1, -1);
    add_row(-1, 0, -1, 7'h00, -1, P_NONE,    3'b101, -1, -1);
    // Masked release holds RELEASE until the mask drops
    add_row(-1, 0, -1, 7'h00, -1, P_DEALLOC, 3'b101, -1, -1);
    add_row( 0, 2, -1, 7'h00, -1, P_NONE,    3'b001, -1, -1);
    add_row(-1, 0,  1, 7'h33, -1, P_NONE,    3'b011, -1, -1);
    add_row(-1, 0, -1, 7'h00,  1, P_WB,      3'b010, -1, 62);
    add_row(-1, 0, -1, 7'h00, -1, P_RELEASE | P_MASK, 3'b001, 30, -1);
    add_row(-1, 0, -1, 7'h00, -1, P_MASK,    3'b011, -1, -1);
    add_row(-1, 0, -1, 7'h00, -1, P_MASK,    3'b011, -1, -1);
    add_row(-1, 0, -1, 7'h00, -1, P_NONE,    3'b011, -1, -1);
    add_row(-1, 0, -1, 7'h00, -1, P_NONE,    3'b101, -1, -1);
    // Flush in ALLOC beats a same-cycle retire
    add_row(-1, 0, -1, 7'h00, -1, P_DEALLOC, 3'b101, -1, -1);
    add_row( 4, 3, -1, 7'h00, -1, P_NONE,    3'b001, -1, -1);
    add_row(-1, 0,  3, 7'h08, -1, P_NONE,    3'b011, -1, -1);
    add_row(-1, 0, -1, 7'h00,  3, P_FLUSH,   3'b010, -1,  0);
    add_row(-1, 0, -1, 7'h00, -1, P_NONE,    3'b101, -1, -1);
    // Flush in WF_ALLOC and flush with dealloc
    add_row(-1, 0, -1, 7'h00, -1, P_DEALLOC, 3'b101, -1, -1);
    add_row( 0, 4, -1, 7'h00, -1, P_FLUSH,   3'b001, -1, -1);
    add_row(-1, 0, -1, 7'h00, -1, P_NONE,    3'b101, -1, -1);
    add_row(-1, 0, -1, 7'h00, -1, P_DEALLOC | P_FLUSH, 3'b101, -1, -1);
    add_row(-1, 0, -1, 7'h00, -1, P_NONE,    3'b101, -1, -1);
  endtask

  //====================
  // Run control
  //====================
  always @(posedge sm_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
      stop_run();
    end
  end

  initial begin
    cpurst_b     = 1'b0;
    disp         = '0;
    create_vld   = '0;
    retire       = '0;
    dealloc_vld  = 1'b0;
    release_vld  = 1'b0;
    wb_vld       = 1'b0;
    flush        = 1'b0;
    dealloc_mask = 1'b0;
    lfsr_state   = 32'd98978;
    cycle_count  = 0;
    cycle_limit  = 0;
    build_table();
    cycle_limit = rows.size() + RESET_CYCLES + 20;
    repeat (RESET_CYCLES) @(posedge sm_clk);
    #1 cpurst_b = 1'b1;
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge sm_clk);
      #1 apply_row(rows[i]);
      #97 check_row(i, rows[i]);
    end
    $display("No errors");
    $finish;
  end

endmodule

// File: vreg_entry.f
rtl/vreg_pkg.sv
rtl/vreg_info_reg.sv
rtl/vreg_retire_match.sv
rtl/vreg_lifecycle_fsm.sv
rtl/vreg_wb_fsm.sv
rtl/vreg_release_decode.sv
rtl/vreg_entry.sv
sim/vreg_entry_sva.sv
sim/vreg_entry_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module vreg_entry_tb -f vreg_entry.f -o vreg_entry_sim

# The simulator exits non-zero on $fatal, so the log decides the result
./obj_dir/vreg_entry_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
if ! grep -q "No errors" sim.log; then
  echo "Simulation FAILED: run ended without a result"
  exit 1
fi
echo "Simulation PASSED"
